// File: design/cache_array.sv
`default_nettype none
`timescale 1ns/100ps

// per-set storage, shared by the tag store and the data store
module cache_array #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     we,
  input  wire [$clog2(DEPTH)-1:0] waddr,
  input  wire payload_t           wdata,
  input  wire [$clog2(DEPTH)-1:0] raddr,
  output payload_t                rdata
);

  payload_t entries [DEPTH];

  // everything cleared on reset so valid and dirty start low
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        entries[i] <= '0;
      end
    end else if (we) begin
      entries[waddr] <= wdata;
    end
  end

  // read is combinational so compare happens in the same cycle
  assign rdata = entries[raddr];

endmodule

`default_nettype wire

// File: design/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// requester byte address
`define ADDR_W 32

// direct mapped, one line per set
`define NUM_SETS 16
`define IDX_W 4

// four words per line
`define LINE_BYTES 16
`define OFS_W 4
`define WORD_SEL_W 2

`define TAG_W 24

// backing memory, 4 KiB of lines
`define MEM_LINES 256
`define MEM_ADDR_W 8
`define MEM_LATENCY 4

`endif

// File: design/cache_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

`include "cache_consts.svh"

module cache_ctrl
  import cache_pkg::*;
  import mem_pkg::*;
(
  input  wire                clk,
  input  wire                reset,
  // requester
  input  wire                req_valid,
  input  wire [`ADDR_W-1:0]  req_addr,
  input  wire                req_write,
  input  wire word_t         req_wdata,
  output logic               req_ready,
  output logic               resp_valid,
  output word_t              resp_rdata,
  output logic               resp_hit,
  // tag store
  output logic               tag_we,
  output tag_entry_t         tag_wdata,
  input  wire tag_entry_t    tag_rdata,
  // data store
  output logic               data_we,
  output line_t              data_wdata,
  input  wire line_t         data_rdata,
  // backing memory
  mem_if.master              mem,
  input  wire line_t         mem_rdata,
  // index shared by both arrays
  output set_idx_t           set_idx
);

  localparam int BYTE_W     = `OFS_W - `WORD_SEL_W;
  localparam int LINE_NUM_W = `ADDR_W - `OFS_W;

  cache_state_t            state;
  cache_state_t            next_state;
  logic [`ADDR_W-1:0]      addr_q;
  logic                    write_q;
  word_t                   wdata_q;
  logic                    miss_seen;
  tag_t                    req_tag;
  word_sel_t               word_sel;
  logic                    hit;
  line_t                   merged_line;
  logic [LINE_NUM_W-1:0]   fill_line;
  logic [LINE_NUM_W-1:0]   victim_line;

  // address split of the latched request
  assign req_tag   = addr_q[`ADDR_W-1 -: `TAG_W];
  assign set_idx   = addr_q[`OFS_W +: `IDX_W];
  assign word_sel  = addr_q[BYTE_W +: `WORD_SEL_W];
  assign fill_line = addr_q[`ADDR_W-1:`OFS_W];
  // victim lives at old tag + same index
  assign victim_line = {tag_rdata.tag, set_idx};

  assign hit = tag_rdata.valid && (tag_rdata.tag == req_tag);

  assign req_ready  = (state == idle);
  assign resp_valid = (state == compare_tag) && hit;
  // a retried compare after a fill still reports a miss
  assign resp_hit   = hit && !miss_seen;
  assign resp_rdata = write_q ? wdata_q : data_rdata[32*word_sel +: 32];

  // write data merged into the current line
  always_comb begin
    merged_line = data_rdata;
    merged_line[32*word_sel +: 32] = wdata_q;
  end

  // request latch, requester need not hold its inputs
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      addr_q  <= req_addr;
      write_q <= req_write;
      wdata_q <= req_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      miss_seen <= 1'b0;
    end else begin
      state <= next_state;
      if (req_valid && req_ready) begin
        miss_seen <= 1'b0;
      end else if (state == compare_tag && !hit) begin
        miss_seen <= 1'b1;
      end
    end
  end

  always_comb begin
    next_state     = state;
    tag_we         = 1'b0;
    tag_wdata      = tag_rdata;
    data_we        = 1'b0;
    data_wdata     = data_rdata;
    mem.req        = 1'b0;
    mem.write      = 1'b0;
    mem.line_addr  = fill_line[`MEM_ADDR_W-1:0];
    mem.wdata      = data_rdata;

    case (state)
      idle: begin
        if (req_valid) begin
          next_state = compare_tag;
        end
      end
      compare_tag: begin
        if (hit) begin
          if (write_q) begin
            data_we    = 1'b1;
            data_wdata = merged_line;
            tag_we     = 1'b1;
            tag_wdata  = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
          end
          next_state = idle;
        end else if (mem.ready) begin
          mem.req = 1'b1;
          if (tag_rdata.valid && tag_rdata.dirty) begin
            // dirty victim goes out first
            mem.write     = 1'b1;
            mem.line_addr = victim_line[`MEM_ADDR_W-1:0];
            next_state    = write_back;
          end else begin
            next_state = allocate;
          end
        end
      end
      write_back: begin
        // memory is idle again in its done cycle, so the fill goes out at once
        if (mem.rvalid) begin
          mem.req    = 1'b1;
          next_state = allocate;
        end
      end
      allocate: begin
        if (mem.rvalid) begin
          data_we    = 1'b1;
          data_wdata = mem_rdata;
          tag_we     = 1'b1;
          tag_wdata  = '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
          next_state = compare_tag;
        end
      end
      default: next_state = idle;
    endcase
  end

endmodule

`default_nettype wire

// File: design/cache_pkg.sv
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

  typedef logic [31:0] word_t;

  typedef logic [`TAG_W-1:0] tag_t;

  typedef logic [`IDX_W-1:0] set_idx_t;

  // word within a line
  typedef logic [`WORD_SEL_W-1:0] word_sel_t;

  // one tag store entry per set
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  typedef enum logic [1:0] {
    idle        = 2'b00,
    compare_tag = 2'b01,
    allocate    = 2'b10,
    write_back  = 2'b11
  } cache_state_t;

endpackage

`default_nettype wire

// File: design/cache_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "cache_consts.svh"

module cache_top
  import cache_pkg::*;
  import mem_pkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire               req_valid,
  input  wire [`ADDR_W-1:0] req_addr,
  input  wire               req_write,
  input  wire word_t        req_wdata,
  output logic              req_ready,
  output logic              resp_valid,
  output word_t             resp_rdata,
  output logic              resp_hit
);

  set_idx_t   set_idx;
  logic       tag_we;
  tag_entry_t tag_wdata;
  tag_entry_t tag_rdata;
  logic       data_we;
  line_t      data_wdata;
  line_t      data_rdata;
  line_t      mem_rdata;

  mem_if mem_bus ();

  cache_ctrl i_cache_ctrl (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_write  (req_write),
    .req_wdata  (req_wdata),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_hit   (resp_hit),
    .tag_we     (tag_we),
    .tag_wdata  (tag_wdata),
    .tag_rdata  (tag_rdata),
    .data_we    (data_we),
    .data_wdata (data_wdata),
    .data_rdata (data_rdata),
    .mem        (mem_bus.master),
    .mem_rdata  (mem_rdata),
    .set_idx    (set_idx)
  );

  // valid, dirty and tag per set
  cache_array #(
    .payload_t (tag_entry_t),
    .DEPTH     (`NUM_SETS)
  ) i_tag_array (
    .clk   (clk),
    .reset (reset),
    .we    (tag_we),
    .waddr (set_idx),
    .wdata (tag_wdata),
    .raddr (set_idx),
    .rdata (tag_rdata)
  );

  cache_array #(
    .payload_t (line_t),
    .DEPTH     (`NUM_SETS)
  ) i_data_array (
    .clk   (clk),
    .reset (reset),
    .we    (data_we),
    .waddr (set_idx),
    .wdata (data_wdata),
    .raddr (set_idx),
    .rdata (data_rdata)
  );

  data_memory i_data_memory (
    .clk   (clk),
    .reset (reset),
    .mem   (mem_bus.slave),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// File: design/data_memory.sv
`default_nettype none
`timescale 1ns/100ps

`include "cache_consts.svh"

module data_memory
  import cache_pkg::*;
  import mem_pkg::*;
(
  input  wire   clk,
  input  wire   reset,
  mem_if.slave  mem,
  output line_t rdata
);

  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

  line_t            lines [`MEM_LINES];
  logic             busy;
  logic [CNT_W-1:0] count;
  logic             rvalid_q;
  logic             write_q;
  line_addr_t       addr_q;
  line_t            wdata_q;
  logic             finish;

  // word w of line l holds l*4 + w
  function automatic line_t init_line(int unsigned l);
    line_t line;
    line = '0;
    for (int unsigned w = 0; w < 4; w++) begin
      line[32*w +: 32] = word_t'(l * 4 + w);
    end
    return line;
  endfunction

  initial begin
    for (int unsigned i = 0; i < `MEM_LINES; i++) begin
      lines[i] = init_line(i);
    end
  end

  assign mem.ready  = ~busy;
  assign mem.rvalid = rvalid_q;
  // last latency cycle
  assign finish     = busy && (count == CNT_W'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      count    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= 1'b0;
      if (!busy && mem.req) begin
        busy  <= 1'b1;
        count <= CNT_W'(`MEM_LATENCY);
      end else if (busy) begin
        count <= count - CNT_W'(1);
        if (finish) begin
          busy     <= 1'b0;
          rvalid_q <= 1'b1;
        end
      end
    end
  end

  // transfer held while the latency runs
  always_ff @(posedge clk) begin
    if (!busy && mem.req) begin
      write_q <= mem.write;
      addr_q  <= mem.line_addr;
      wdata_q <= mem.wdata;
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      for (int unsigned i = 0; i < `MEM_LINES; i++) begin
        lines[i] <= init_line(i);
      end
    end else if (finish && write_q) begin
      lines[addr_q] <= wdata_q;
    end
  end

  always_ff @(posedge clk) begin
    if (finish && !write_q) begin
      rdata <= lines[addr_q];
    end
  end

endmodule

`default_nettype wire

// File: design/mem_if.sv
`default_nettype none
`timescale 1ns/100ps

// line transfers between controller and backing memory
interface mem_if
  import mem_pkg::*;
();

  // request side, one cycle per transfer
  logic       req;
  logic       write;
  line_addr_t line_addr;
  line_t      wdata;

  // memory idle
  logic       ready;
  // done pulse, read data valid in the same cycle
  logic       rvalid;

  modport master (
    output req,
    output write,
    output line_addr,
    output wdata,
    input  ready,
    input  rvalid
  );

  modport slave (
    input  req,
    input  write,
    input  line_addr,
    input  wdata,
    output ready,
    output rvalid
  );

endinterface

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none

`include "cache_consts.svh"

package mem_pkg;

  // word 0 sits in the low bits
  typedef logic [`LINE_BYTES*8-1:0] line_t;

  // byte address >> OFS_W, truncated
  typedef logic [`MEM_ADDR_W-1:0] line_addr_t;

endpackage

`default_nettype wire

// File: filelist.f
+incdir+design
design/cache_pkg.sv
design/mem_pkg.sv
design/mem_if.sv
design/cache_array.sv
design/cache_ctrl.sv
design/data_memory.sv
design/cache_top.sv
verification/cache_asserts.sv
verification/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f filelist.f --top-module cache_tb -o cache_sim
status=0
./obj_dir/cache_sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -eq 0 ] && grep -q "^=== PASS ===$" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// File: verification/cache_asserts.sv
`default_nettype none
`timescale 1ns/100ps

// protocol checks on the cache controller
module cache_asserts
  import cache_pkg::*;
(
  input wire               clk,
  input wire               reset,
  input wire               req_valid,
  input wire               req_ready,
  input wire               resp_valid,
  input wire               resp_hit,
  input wire               mem_req,
  input wire               mem_ready,
  input wire cache_state_t state
);

  // idle runs from a response until the next acceptance
  ready_only_in_idle: assert property (
    @(posedge clk) disable iff (reset)
    req_ready == ($past(resp_valid) || ($past(req_ready) && !$past(req_valid)))
  ) else $error("req_ready does not follow the request handshake");

  resp_single_cycle: assert property (
    @(posedge clk) disable iff (reset) resp_valid |=> !resp_valid
  ) else $error("resp_valid stayed high for more than one cycle");

  mem_req_when_ready: assert property (
    @(posedge clk) disable iff (reset) mem_req |-> mem_ready
  ) else $error("memory request issued while the memory was busy");

  // a hit answers in the cycle right after acceptance
  hit_next_cycle: assert property (
    @(posedge clk) disable iff (reset)
    (resp_valid && resp_hit) |-> $past(state == idle && req_valid)
  ) else $error("a hit response did not come one cycle after acceptance");

endmodule

bind cache_ctrl cache_asserts i_cache_asserts (
  .clk        (clk),
  .reset      (reset),
  .req_valid  (req_valid),
  .req_ready  (req_ready),
  .resp_valid (resp_valid),
  .resp_hit   (resp_hit),
  .mem_req    (mem.req),
  .mem_ready  (mem.ready),
  .state      (state)
);

`default_nettype wire

// File: verification/cache_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "cache_consts.svh"

module cache_tb
  import cache_pkg::*;
();

  localparam int          SHADOW_WORDS   = `MEM_LINES * 4;
  localparam int          WORD_IDX_W     = $clog2(SHADOW_WORDS);
  localparam int          NUM_DIRECTED   = 15;
  localparam int          NUM_RANDOM     = 300;
  localparam int unsigned TIMEOUT_CYCLES =
    (NUM_DIRECTED + NUM_RANDOM) * (2 * `MEM_LATENCY + 6) + 100;
  localparam logic [31:0] SEED           = 32'h43f0_1ccb;

  logic               clk = 1'b0;
  logic               reset;
  logic               req_valid;
  logic [`ADDR_W-1:0] req_addr;
  logic               req_write;
  word_t              req_wdata;
  logic               req_ready;
  logic               resp_valid;
  word_t              resp_rdata;
  logic               resp_hit;

  // shadow of memory contents and of the tag store
  word_t       shadow_mem   [SHADOW_WORDS];
  logic        shadow_valid [`NUM_SETS];
  logic        shadow_dirty [`NUM_SETS];
  int unsigned shadow_tag   [`NUM_SETS];

  // request in flight
  logic [`ADDR_W-1:0] exp_addr;
  word_t              exp_rdata;
  logic               exp_hit;
  int unsigned        exp_latency;
  int unsigned        accept_cycle;

  int unsigned cycles = 0;
  int unsigned requests = 0;
  int unsigned responses = 0;
  int unsigned data_errors = 0;
  int unsigned hit_errors = 0;
  int unsigned latency_errors = 0;
  int unsigned other_errors = 0;

  cache_top i_cache_top (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_write  (req_write),
    .req_wdata  (req_wdata),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_hit   (resp_hit)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  function automatic void init_shadow();
    for (int i = 0; i < SHADOW_WORDS; i++) begin
      // word w of line l holds l*4 + w
      shadow_mem[i] = word_t'((i / 4) * 4 + (i % 4));
    end
    for (int s = 0; s < `NUM_SETS; s++) begin
      shadow_valid[s] = 1'b0;
      shadow_dirty[s] = 1'b0;
      shadow_tag[s]   = 0;
    end
  endfunction

  // expected data, hit and latency, then update the shadow state
  task automatic predict_access(input logic [`ADDR_W-1:0] addr, input logic write,
                                input word_t wdata);
    logic [WORD_IDX_W-1:0] word_idx;
    set_idx_t              set_num;
    int unsigned           tag;
    word_idx = WORD_IDX_W'(addr / 4);
    set_num  = set_idx_t'(addr / `LINE_BYTES);
    tag      = addr / (`LINE_BYTES * `NUM_SETS);
    exp_hit  = shadow_valid[set_num] && (shadow_tag[set_num] == tag);
    if (exp_hit) begin
      exp_latency = 1;
    end else if (shadow_valid[set_num] && shadow_dirty[set_num]) begin
      exp_latency = 2 * `MEM_LATENCY + 4;
    end else begin
      exp_latency = `MEM_LATENCY + 3;
    end
    if (!exp_hit) begin
      shadow_valid[set_num] = 1'b1;
      shadow_dirty[set_num] = 1'b0;
      shadow_tag[set_num]   = tag;
    end
    if (write) begin
      shadow_mem[word_idx]  = wdata;
      shadow_dirty[set_num] = 1'b1;
    end
    exp_rdata = shadow_mem[word_idx];
    exp_addr  = addr;
  endtask

  task automatic access(input logic [`ADDR_W-1:0] addr, input logic write, input word_t wdata);
    @(posedge clk);
    predict_access(addr, write, wdata);
    req_valid <= 1'b1;
    req_addr  <= addr;
    req_write <= write;
    req_wdata <= wdata;
    @(posedge clk);
    accept_cycle = cycles;
    requests++;
    // inputs dropped, the controller has latched them
    req_valid <= 1'b0;
    req_addr  <= '0;
    req_write <= 1'b0;
    req_wdata <= '0;
    do begin
      @(negedge clk);
    end while (!resp_valid);
  endtask

  always @(negedge clk) begin
    if (!reset && resp_valid) begin
      responses++;
      assert (resp_rdata == exp_rdata) else begin
        $display("error: resp_rdata at address %h is %h, expected %h",
                 exp_addr, resp_rdata, exp_rdata);
        data_errors++;
      end
      assert (resp_hit == exp_hit) else begin
        $display("error: resp_hit at address %h is %h, expected %h", exp_addr, resp_hit, exp_hit);
        hit_errors++;
      end
      assert (cycles - accept_cycle == exp_latency) else begin
        $display("error: response latency at address %h is %h, expected %h",
                 exp_addr, cycles - accept_cycle, exp_latency);
        latency_errors++;
      end
    end
  end

  task automatic run_directed();
    // cold miss, then hits on the rest of the line
    access(32'h0000_0100, 1'b0, '0);
    access(32'h0000_0104, 1'b0, '0);
    access(32'h0000_0108, 1'b0, '0);
    access(32'h0000_010c, 1'b0, '0);
    // write hit, read back, neighbour untouched
    access(32'h0000_0108, 1'b1, 32'hdead_beef);
    access(32'h0000_0108, 1'b0, '0);
    access(32'h0000_010c, 1'b0, '0);
    // same set, other tag evicts the dirty line
    access(32'h0000_0104, 1'b1, 32'h0bad_cafe);
    access(32'h0000_0300, 1'b0, '0);
    access(32'h0000_0104, 1'b0, '0);
    // write miss allocates
    access(32'h0000_05f8, 1'b1, 32'h1357_9bdf);
    access(32'h0000_05f0, 1'b0, '0);
    access(32'h0000_05f4, 1'b0, '0);
    access(32'h0000_05f8, 1'b0, '0);
    access(32'h0000_05fc, 1'b0, '0);
  endtask

  task automatic run_random();
    int unsigned line;
    int unsigned word;
    logic        write;
    line = $urandom % `MEM_LINES;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      // stay on the last line half the time so hits occur
      if ($urandom % 2 == 0) begin
        line = $urandom % `MEM_LINES;
      end
      word  = $urandom % 4;
      write = ($urandom % 2) == 1;
      access(`ADDR_W'(line * `LINE_BYTES + word * 4), write, $urandom);
    end
  endtask

  function automatic void print_summary();
    $display("summary: %0d responses, %0d data errors, %0d hit errors, %0d latency errors, %0d other errors",
             responses, data_errors, hit_errors, latency_errors, other_errors);
  endfunction

  initial begin
    reset     = 1'b1;
    req_valid = 1'b0;
    req_addr  = '0;
    req_write = 1'b0;
    req_wdata = '0;
    void'($urandom(SEED));
    init_shadow();
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (req_ready && !resp_valid) else begin
      $display("the cache was not ready for requests after reset");
      other_errors++;
    end
    run_directed();
    run_random();
    @(posedge clk);
    assert (responses == requests) else begin
      $display("%0d requests were accepted but %0d responses came back", requests, responses);
      other_errors++;
    end
    print_summary();
    if (data_errors + hit_errors + latency_errors + other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    wait (cycles >= TIMEOUT_CYCLES);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    print_summary();
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire
